//--- list.f
+incdir+sim
hw/fp8_pkg.sv
hw/fp8_addsub.sv
hw/fp8_mul.sv
hw/fp8_engine.sv
hw/scratch_arbiter.sv
hw/fp8_scratchpad.sv
hw/fp8_cluster_top.sv
sim/fp8_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the fp8 cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f list.f --top-module fp8_tb -o fp8_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/fp8_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    echo "Testbench reported failure"
    exit 1
fi

exit 0

//--- sim/fp8_model.svh
`ifndef FP8_MODEL_SVH
`define FP8_MODEL_SVH

// Add/subtract on signed integer mantissas with the hidden one included
function automatic fp8_t model_addsub(input fp8_t a, input fp8_t b, input logic sub);
    int   ea;
    int   eb;
    int   va;
    int   vb;
    int   e;
    int   s;
    logic sgn;
    ea = int'(a[FP8_EXP_HI:FP8_EXP_LO]);
    eb = int'(b[FP8_EXP_HI:FP8_EXP_LO]);
    va = (ea != 0) ? 16 + int'(a[FP8_MANT_HI:0]) : int'(a[FP8_MANT_HI:0]);
    vb = (eb != 0) ? 16 + int'(b[FP8_MANT_HI:0]) : int'(b[FP8_MANT_HI:0]);
    // Smaller operand loses its low bits
    if (ea > eb) begin
        vb = vb >> (ea - eb);
        e  = ea;
    end else begin
        va = va >> (eb - ea);
        e  = eb;
    end
    if (a[FP8_SIGN_BIT]) va = -va;
    if (b[FP8_SIGN_BIT] ^ sub) vb = -vb;
    s   = va + vb;
    sgn = (s < 0);
    if (s < 0) s = -s;
    if (s == 0) return '0;
    if (s >= 32) begin
        s = s >> 1;
        e = e + 1;
    end
    while (s < 16) begin
        s = s << 1;
        e = e - 1;
    end
    if (e <= 0) return '0;
    if (e > FP8_EXP_MAX) return {sgn, FP8_MAX_MAG};
    return {sgn, e[2:0], s[3:0]};
endfunction

// Multiply where a zero exponent on either side gives +0
function automatic fp8_t model_mul(input fp8_t a, input fp8_t b, input logic negate);
    int   e;
    int   p;
    logic sgn;
    sgn = a[FP8_SIGN_BIT] ^ b[FP8_SIGN_BIT] ^ negate;
    if (a[FP8_EXP_HI:FP8_EXP_LO] == 3'd0 || b[FP8_EXP_HI:FP8_EXP_LO] == 3'd0) return '0;
    e = int'(a[FP8_EXP_HI:FP8_EXP_LO]) + int'(b[FP8_EXP_HI:FP8_EXP_LO]) - FP8_BIAS;
    p = (16 + int'(a[FP8_MANT_HI:0])) * (16 + int'(b[FP8_MANT_HI:0]));
    if (p >= 512) begin
        p = p >> 1;
        e = e + 1;
    end
    if (e <= 0) return '0;
    if (e > FP8_EXP_MAX) return {sgn, FP8_MAX_MAG};
    return {sgn, e[2:0], p[7:4]};
endfunction

`endif

//--- sim/fp8_tb.sv
`timescale 1ns/1ps

module fp8_tb
    import fp8_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int N_ADD        = 24;
    localparam int N_MUL        = 24;
    localparam int N_CONT       = 10;
    localparam int N_EDGE       = 8;
    // Host accesses and engine jobs over the whole run
    localparam int OP_COUNT = 2 * SP_DEPTH + 2 * (N_ADD + N_MUL) + 8 * N_CONT + 4 * N_EDGE;
    localparam int WATCHDOG_CYCLES = OP_COUNT * 40 + 200;

    logic     clk;
    logic     rst_n;
    logic     add_start;
    logic     add_op;
    sp_addr_t add_src_a;
    sp_addr_t add_src_b;
    sp_addr_t add_dst;
    logic     add_busy;
    logic     add_done;
    logic     mul_start;
    logic     mul_op;
    sp_addr_t mul_src_a;
    sp_addr_t mul_src_b;
    sp_addr_t mul_dst;
    logic     mul_busy;
    logic     mul_done;
    logic     host_req;
    logic     host_we;
    sp_addr_t host_addr;
    fp8_t     host_wdata;
    logic     host_gnt;
    logic     host_rvalid;
    fp8_t     host_rdata;

    // Expected scratchpad contents
    fp8_t     shadow [SP_DEPTH];
    int       errors;
    int       checks;

    // Command applied by the next launch
    logic     cmd_add_op;
    sp_addr_t cmd_add_a;
    sp_addr_t cmd_add_b;
    sp_addr_t cmd_add_d;
    logic     cmd_mul_op;
    sp_addr_t cmd_mul_a;
    sp_addr_t cmd_mul_b;
    sp_addr_t cmd_mul_d;
    logic     add_fin;
    logic     mul_fin;

    `include "fp8_model.svh"

    fp8_cluster_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles, errors: %0d",
                 WATCHDOG_CYCLES, errors);
        $display("Verification failed");
        $finish;
    end

    task automatic check_val(input logic [7:0] actual, input logic [7:0] expected,
                             input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    // One host access with the request held until granted
    task automatic host_access(input logic we, input sp_addr_t addr, input fp8_t wdata,
                               output fp8_t rdata);
        @(posedge clk);
        host_req   <= 1'b1;
        host_we    <= we;
        host_addr  <= addr;
        host_wdata <= wdata;
        @(negedge clk);
        while (!host_gnt) @(negedge clk);
        @(posedge clk);
        host_req <= 1'b0;
        rdata = 'x;
        if (!we) begin
            @(negedge clk);
            check_val(8'(host_rvalid), 8'd1, "host rvalid one cycle after read grant");
            rdata = host_rdata;
        end
    endtask

    task automatic host_write(input sp_addr_t addr, input fp8_t data);
        fp8_t unused;
        host_access(1'b1, addr, data, unused);
        shadow[addr] = data;
    endtask

    task automatic check_read(input sp_addr_t addr);
        fp8_t got;
        host_access(1'b0, addr, '0, got);
        check_val(got, shadow[addr], $sformatf("host read of entry %0d", addr));
    endtask

    task automatic launch(input logic go_add, input logic go_mul);
        @(posedge clk);
        add_start <= go_add;
        add_op    <= cmd_add_op;
        add_src_a <= cmd_add_a;
        add_src_b <= cmd_add_b;
        add_dst   <= cmd_add_d;
        mul_start <= go_mul;
        mul_op    <= cmd_mul_op;
        mul_src_a <= cmd_mul_a;
        mul_src_b <= cmd_mul_b;
        mul_dst   <= cmd_mul_d;
        @(posedge clk);
        add_start <= 1'b0;
        mul_start <= 1'b0;
    endtask

    // Counts cycles from the start cycle up to the done pulse
    task automatic wait_done(input logic is_mul, output int cycles);
        logic done_now;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles == 1) begin
                check_val(8'(is_mul ? mul_busy : add_busy), 8'd1, "busy after start");
            end
            done_now = is_mul ? mul_done : add_done;
        end while (!done_now);
        check_val(8'(is_mul ? mul_busy : add_busy), 8'd0, "busy low with done");
    endtask

    task automatic run_op(input logic is_mul, input logic op, input sp_addr_t sa,
                          input sp_addr_t sb, input sp_addr_t d, output fp8_t res);
        fp8_t expected;
        int   cycles;
        if (is_mul) begin
            expected   = model_mul(shadow[sa], shadow[sb], op);
            cmd_mul_op = op;
            cmd_mul_a  = sa;
            cmd_mul_b  = sb;
            cmd_mul_d  = d;
        end else begin
            expected   = model_addsub(shadow[sa], shadow[sb], op);
            cmd_add_op = op;
            cmd_add_a  = sa;
            cmd_add_b  = sb;
            cmd_add_d  = d;
        end
        launch(!is_mul, is_mul);
        wait_done(is_mul, cycles);
        // Uncontended job takes six cycles
        check_val(8'(cycles), 8'd6, "engine latency");
        shadow[d] = expected;
        host_access(1'b0, d, '0, res);
        check_val(res, expected, $sformatf("%s result in entry %0d",
                  is_mul ? "mul" : "add", d));
    endtask

    task automatic edge_case(input logic is_mul, input logic op, input fp8_t a,
                             input fp8_t b, output fp8_t res);
        host_write(4'd0, a);
        host_write(4'd1, b);
        run_op(is_mul, op, 4'd0, 4'd1, 4'd2, res);
    endtask

    // Both engines on disjoint entries while the host reads the rest
    task automatic contention_round();
        sp_addr_t perm [SP_DEPTH];
        sp_addr_t tmp;
        int       j;
        int       cyc_a;
        int       cyc_m;
        fp8_t     exp_add;
        fp8_t     exp_mul;
        for (int i = 0; i < SP_DEPTH; i++) perm[i] = sp_addr_t'(i);
        for (int i = SP_DEPTH - 1; i > 0; i--) begin
            j       = int'($urandom % (i + 1));
            tmp     = perm[i];
            perm[i] = perm[j];
            perm[j] = tmp;
        end
        cmd_add_op = 1'($urandom);
        cmd_add_a  = perm[0];
        cmd_add_b  = perm[1];
        cmd_add_d  = perm[2];
        cmd_mul_op = 1'($urandom);
        cmd_mul_a  = perm[3];
        cmd_mul_b  = perm[4];
        cmd_mul_d  = perm[5];
        exp_add = model_addsub(shadow[perm[0]], shadow[perm[1]], cmd_add_op);
        exp_mul = model_mul(shadow[perm[3]], shadow[perm[4]], cmd_mul_op);
        add_fin = 1'b0;
        mul_fin = 1'b0;
        launch(1'b1, 1'b1);
        fork
            begin
                wait_done(1'b0, cyc_a);
                add_fin = 1'b1;
            end
            begin
                wait_done(1'b1, cyc_m);
                mul_fin = 1'b1;
            end
            begin
                while (!(add_fin && mul_fin)) check_read(perm[6 + int'($urandom % 10)]);
            end
        join
        // Waiting for the arbiter can only add cycles
        check_val(8'(cyc_a >= 6), 8'd1, "add latency under contention");
        check_val(8'(cyc_m >= 6), 8'd1, "mul latency under contention");
        shadow[perm[2]] = exp_add;
        shadow[perm[5]] = exp_mul;
        check_read(perm[2]);
        check_read(perm[5]);
    endtask

    initial begin
        fp8_t     res;
        sp_addr_t sa;
        sp_addr_t sb;
        void'($urandom(45084));
        errors     = 0;
        checks     = 0;
        rst_n      = 1'b0;
        add_start  = 1'b0;
        add_op     = 1'b0;
        add_src_a  = '0;
        add_src_b  = '0;
        add_dst    = '0;
        mul_start  = 1'b0;
        mul_op     = 1'b0;
        mul_src_a  = '0;
        mul_src_b  = '0;
        mul_dst    = '0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val(8'(add_busy), 8'd0, "add_busy after reset");
        check_val(8'(mul_busy), 8'd0, "mul_busy after reset");
        check_val(8'(add_done), 8'd0, "add_done after reset");
        check_val(8'(mul_done), 8'd0, "mul_done after reset");
        check_val(8'(host_gnt), 8'd0, "host_gnt after reset");
        check_val(8'(host_rvalid), 8'd0, "host_rvalid after reset");

        for (int i = 0; i < SP_DEPTH; i++) host_write(sp_addr_t'(i), fp8_t'($urandom));
        for (int i = 0; i < SP_DEPTH; i++) check_read(sp_addr_t'(i));

        // Fresh random operands before every job
        for (int n = 0; n < N_ADD + N_MUL; n++) begin
            sa = sp_addr_t'($urandom);
            sb = sp_addr_t'($urandom);
            host_write(sa, fp8_t'($urandom));
            host_write(sb, fp8_t'($urandom));
            run_op(n >= N_ADD, 1'($urandom), sa, sb, sp_addr_t'($urandom), res);
        end

        repeat (N_CONT) contention_round();

        edge_case(1'b0, 1'b0, 8'h05, 8'h13, res);
        edge_case(1'b1, 1'b0, 8'h05, 8'h35, res);
        check_val(res, 8'h00, "mul with exponent-zero operand");
        edge_case(1'b0, 1'b1, 8'h3A, 8'h3A, res);
        check_val(res, 8'h00, "exact cancellation by subtract");
        edge_case(1'b0, 1'b0, 8'h3A, 8'hBA, res);
        check_val(res, 8'h00, "exact cancellation by opposite signs");
        edge_case(1'b0, 1'b0, 8'h7F, 8'h7F, res);
        check_val(8'(res[6:0]), 8'(FP8_MAX_MAG), "add overflow magnitude");
        edge_case(1'b1, 1'b1, 8'h70, 8'h70, res);
        check_val(res, {1'b1, FP8_MAX_MAG}, "negated mul overflow");
        edge_case(1'b1, 1'b0, 8'h10, 8'h10, res);
        check_val(res, 8'h00, "mul underflow");
        edge_case(1'b0, 1'b1, 8'h12, 8'h11, res);
        check_val(res, 8'h00, "subtract underflow");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- hw/fp8_cluster_top.sv
`timescale 1ns/1ps

module fp8_cluster_top
    import fp8_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     add_start,
    input  logic     add_op,
    input  sp_addr_t add_src_a,
    input  sp_addr_t add_src_b,
    input  sp_addr_t add_dst,
    output logic     add_busy,
    output logic     add_done,

    input  logic     mul_start,
    input  logic     mul_op,
    input  sp_addr_t mul_src_a,
    input  sp_addr_t mul_src_b,
    input  sp_addr_t mul_dst,
    output logic     mul_busy,
    output logic     mul_done,

    input  logic     host_req,
    input  logic     host_we,
    input  sp_addr_t host_addr,
    input  fp8_t     host_wdata,
    output logic     host_gnt,
    output logic     host_rvalid,
    output fp8_t     host_rdata
);

    client_t  cl_req;
    client_t  cl_we;
    client_t  cl_gnt;
    client_t  cl_rvalid;
    sp_addr_t add_mem_addr;
    sp_addr_t mul_mem_addr;
    fp8_t     add_mem_wdata;
    fp8_t     mul_mem_wdata;
    logic     sp_en;
    logic     sp_we;
    sp_addr_t sp_addr;
    fp8_t     sp_wdata;
    fp8_t     sp_rdata;

    // Engine to arithmetic unit
    fp8_t     add_opnd_a;
    fp8_t     add_opnd_b;
    logic     add_mode;
    fp8_t     add_result;
    fp8_t     mul_opnd_a;
    fp8_t     mul_opnd_b;
    logic     mul_mode;
    fp8_t     mul_result;

    assign cl_req[CLIENT_HOST] = host_req;
    assign cl_we[CLIENT_HOST]  = host_we;
    assign host_gnt            = cl_gnt[CLIENT_HOST];
    assign host_rvalid         = cl_rvalid[CLIENT_HOST];
    assign host_rdata          = sp_rdata;

    fp8_engine u_add_eng (
        .clk(clk), .rst_n(rst_n),
        .start(add_start), .op(add_op),
        .src_a(add_src_a), .src_b(add_src_b), .dst(add_dst),
        .busy(add_busy), .done(add_done),
        .mem_req(cl_req[CLIENT_ADD]), .mem_we(cl_we[CLIENT_ADD]),
        .mem_addr(add_mem_addr), .mem_wdata(add_mem_wdata),
        .mem_gnt(cl_gnt[CLIENT_ADD]), .mem_rvalid(cl_rvalid[CLIENT_ADD]),
        .mem_rdata(sp_rdata),
        .opnd_a(add_opnd_a), .opnd_b(add_opnd_b), .op_mode(add_mode),
        .result(add_result)
    );

    fp8_engine u_mul_eng (
        .clk(clk), .rst_n(rst_n),
        .start(mul_start), .op(mul_op),
        .src_a(mul_src_a), .src_b(mul_src_b), .dst(mul_dst),
        .busy(mul_busy), .done(mul_done),
        .mem_req(cl_req[CLIENT_MUL]), .mem_we(cl_we[CLIENT_MUL]),
        .mem_addr(mul_mem_addr), .mem_wdata(mul_mem_wdata),
        .mem_gnt(cl_gnt[CLIENT_MUL]), .mem_rvalid(cl_rvalid[CLIENT_MUL]),
        .mem_rdata(sp_rdata),
        .opnd_a(mul_opnd_a), .opnd_b(mul_opnd_b), .op_mode(mul_mode),
        .result(mul_result)
    );

    fp8_addsub u_addsub (
        .a(add_opnd_a), .b(add_opnd_b), .operation(add_mode), .result(add_result)
    );

    fp8_mul u_mul (
        .a(mul_opnd_a), .b(mul_opnd_b), .negate(mul_mode), .result(mul_result)
    );

    scratch_arbiter u_arb (
        .clk(clk), .rst_n(rst_n),
        .req(cl_req), .we(cl_we),
        .addr0(host_addr), .addr1(add_mem_addr), .addr2(mul_mem_addr),
        .wdata0(host_wdata), .wdata1(add_mem_wdata), .wdata2(mul_mem_wdata),
        .gnt(cl_gnt), .rvalid(cl_rvalid),
        .sp_en(sp_en), .sp_we(sp_we), .sp_addr(sp_addr), .sp_wdata(sp_wdata)
    );

    fp8_scratchpad u_sp (
        .clk(clk), .en(sp_en), .we(sp_we),
        .addr(sp_addr), .wdata(sp_wdata), .rdata(sp_rdata)
    );

endmodule

//--- hw/fp8_scratchpad.sv
`timescale 1ns/1ps

module fp8_scratchpad
    import fp8_pkg::*;
(
    input  logic     clk,
    input  logic     en,
    input  logic     we,
    input  sp_addr_t addr,
    input  fp8_t     wdata,
    output fp8_t     rdata
);

    fp8_t mem [SP_DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                // Registered read with data valid the next cycle
                rdata <= mem[addr];
            end
        end
    end

endmodule

//--- hw/scratch_arbiter.sv
`timescale 1ns/1ps

module scratch_arbiter
    import fp8_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  client_t  req,
    input  client_t  we,
    input  sp_addr_t addr0,
    input  sp_addr_t addr1,
    input  sp_addr_t addr2,
    input  fp8_t     wdata0,
    input  fp8_t     wdata1,
    input  fp8_t     wdata2,
    output client_t  gnt,
    output client_t  rvalid,

    output logic     sp_en,
    output logic     sp_we,
    output sp_addr_t sp_addr,
    output fp8_t     sp_wdata
);

    sp_addr_t   addr_arr  [NUM_CLIENTS];
    fp8_t       wdata_arr [NUM_CLIENTS];
    // Client with the highest priority this cycle
    logic [1:0] ptr;
    logic [1:0] gnt_idx;
    logic [2:0] cand;

    assign addr_arr[0]  = addr0;
    assign addr_arr[1]  = addr1;
    assign addr_arr[2]  = addr2;
    assign wdata_arr[0] = wdata0;
    assign wdata_arr[1] = wdata1;
    assign wdata_arr[2] = wdata2;

    // Walk from the farthest client back so the nearest requester wins
    always_comb begin
        gnt_idx = ptr;
        cand    = '0;
        for (int i = NUM_CLIENTS - 1; i >= 0; i--) begin
            cand = {1'b0, ptr} + 3'(i);
            if (cand >= NUM_CLIENTS) cand = cand - 3'(NUM_CLIENTS);
            if (req[cand[1:0]]) gnt_idx = cand[1:0];
        end
        gnt = (|req) ? (client_t'(1) << gnt_idx) : '0;
    end

    assign sp_en    = |req;
    assign sp_we    = |(gnt & we);
    assign sp_addr  = addr_arr[gnt_idx];
    assign sp_wdata = wdata_arr[gnt_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr    <= '0;
            rvalid <= '0;
        end else begin
            rvalid <= gnt & ~we;
            if (|req) begin
                ptr <= (gnt_idx == 2'(NUM_CLIENTS - 1)) ? 2'd0 : gnt_idx + 2'd1;
            end
        end
    end

endmodule

//--- hw/fp8_engine.sv
`timescale 1ns/1ps

module fp8_engine
    import fp8_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     start,
    input  logic     op,
    input  sp_addr_t src_a,
    input  sp_addr_t src_b,
    input  sp_addr_t dst,
    output logic     busy,
    output logic     done,

    output logic     mem_req,
    output logic     mem_we,
    output sp_addr_t mem_addr,
    output fp8_t     mem_wdata,
    input  logic     mem_gnt,
    input  logic     mem_rvalid,
    input  fp8_t     mem_rdata,

    output fp8_t     opnd_a,
    output fp8_t     opnd_b,
    output logic     op_mode,
    input  fp8_t     result
);

    eng_state_t state;
    sp_addr_t   src_a_q;
    sp_addr_t   src_b_q;
    sp_addr_t   dst_q;
    fp8_t       res_q;
    // Read of b granted and its data still pending
    logic       b_issued;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ENG_IDLE;
            b_issued <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ENG_IDLE: begin
                    if (start) state <= ENG_RD_A;
                end
                ENG_RD_A: begin
                    if (mem_gnt) state <= ENG_RD_B;
                end
                ENG_RD_B: begin
                    if (mem_gnt) b_issued <= 1'b1;
                    if (mem_rvalid && b_issued) begin
                        b_issued <= 1'b0;
                        state    <= ENG_EXEC;
                    end
                end
                ENG_EXEC: begin
                    state <= ENG_WR;
                end
                ENG_WR: begin
                    if (mem_gnt) begin
                        state <= ENG_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Command, operands and result
    always_ff @(posedge clk) begin
        if (state == ENG_IDLE && start) begin
            src_a_q <= src_a;
            src_b_q <= src_b;
            dst_q   <= dst;
            op_mode <= op;
        end
        // Data for a always arrives in the first RD_B cycle
        if (state == ENG_RD_B && mem_rvalid) begin
            if (b_issued) opnd_b <= mem_rdata;
            else          opnd_a <= mem_rdata;
        end
        if (state == ENG_EXEC) res_q <= result;
    end

    assign busy = (state != ENG_IDLE);

    assign mem_req   = (state == ENG_RD_A) || (state == ENG_RD_B && !b_issued) ||
                       (state == ENG_WR);
    assign mem_we    = (state == ENG_WR);
    assign mem_wdata = res_q;

    always_comb begin
        case (state)
            ENG_RD_A: mem_addr = src_a_q;
            ENG_RD_B: mem_addr = src_b_q;
            ENG_WR:   mem_addr = dst_q;
            default:  mem_addr = '0;
        endcase
    end

endmodule

//--- hw/fp8_mul.sv
`timescale 1ns/1ps

module fp8_mul
    import fp8_pkg::*;
(
    input  fp8_t a,
    input  fp8_t b,
    input  logic negate,
    output fp8_t result
);

    logic              res_sign;
    exp_t              exp_a;
    exp_t              exp_b;
    logic [4:0]        mant_a;
    logic [4:0]        mant_b;
    logic [9:0]        product;
    mant_t             res_mant;
    logic signed [4:0] res_exp;

    assign exp_a = a[FP8_EXP_HI:FP8_EXP_LO];
    assign exp_b = b[FP8_EXP_HI:FP8_EXP_LO];

    assign res_sign = a[FP8_SIGN_BIT] ^ b[FP8_SIGN_BIT] ^ negate;

    // Zero exponents are caught below, so the hidden one is always set here
    assign mant_a  = {1'b1, a[FP8_MANT_HI:0]};
    assign mant_b  = {1'b1, b[FP8_MANT_HI:0]};
    assign product = mant_a * mant_b;

    always_comb begin
        res_exp = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) - 5'(FP8_BIAS);

        // Product in [1,4) needs at most one right shift
        if (product[9]) begin
            res_mant = product[8:5];
            res_exp  = res_exp + 5'sd1;
        end else begin
            res_mant = product[7:4];
        end

        if (exp_a == '0 || exp_b == '0 || res_exp <= 5'sd0) begin
            result = '0;
        end else if (res_exp > FP8_EXP_MAX) begin
            result = {res_sign, FP8_MAX_MAG};
        end else begin
            result = {res_sign, exp_t'(res_exp[2:0]), res_mant};
        end
    end

endmodule

//--- hw/fp8_addsub.sv
`timescale 1ns/1ps

module fp8_addsub
    import fp8_pkg::*;
(
    input  fp8_t a,
    input  fp8_t b,
    input  logic operation,
    output fp8_t result
);

    logic              b_sign;
    logic              res_sign;
    exp_t              exp_a;
    exp_t              exp_b;
    exp_t              big_exp;
    exp_t              exp_diff;
    logic [4:0]        mant_a;
    logic [4:0]        mant_b;
    logic [4:0]        aligned_a;
    logic [4:0]        aligned_b;
    logic [5:0]        mant_sum;
    logic [5:0]        norm_mant;
    logic [2:0]        lead_shift;
    logic signed [4:0] res_exp;

    assign exp_a  = a[FP8_EXP_HI:FP8_EXP_LO];
    assign exp_b  = b[FP8_EXP_HI:FP8_EXP_LO];
    // Subtraction flips the sign of b
    assign b_sign = b[FP8_SIGN_BIT] ^ operation;

    // Hidden one only for a nonzero exponent
    assign mant_a = {(exp_a != '0), a[FP8_MANT_HI:0]};
    assign mant_b = {(exp_b != '0), b[FP8_MANT_HI:0]};

    always_comb begin
        // Shift the smaller operand toward the larger exponent
        if (exp_a > exp_b) begin
            exp_diff  = exp_a - exp_b;
            aligned_a = mant_a;
            aligned_b = mant_b >> exp_diff;
            big_exp   = exp_a;
        end else begin
            exp_diff  = exp_b - exp_a;
            aligned_a = mant_a >> exp_diff;
            aligned_b = mant_b;
            big_exp   = exp_b;
        end

        if (a[FP8_SIGN_BIT] == b_sign) begin
            mant_sum = aligned_a + aligned_b;
            res_sign = b_sign;
        end else if (aligned_a >= aligned_b) begin
            mant_sum = aligned_a - aligned_b;
            res_sign = a[FP8_SIGN_BIT];
        end else begin
            mant_sum = aligned_b - aligned_a;
            res_sign = b_sign;
        end

        // Carry out moves right, otherwise search for the leading one
        lead_shift = 3'd0;
        if (mant_sum[5]) begin
            norm_mant = mant_sum >> 1;
            res_exp   = $signed({2'b00, big_exp}) + 5'sd1;
        end else begin
            if (mant_sum[4])      lead_shift = 3'd0;
            else if (mant_sum[3]) lead_shift = 3'd1;
            else if (mant_sum[2]) lead_shift = 3'd2;
            else if (mant_sum[1]) lead_shift = 3'd3;
            else                  lead_shift = 3'd4;
            norm_mant = mant_sum << lead_shift;
            res_exp   = $signed({2'b00, big_exp}) - $signed({2'b00, lead_shift});
        end

        // Flush to +0, saturate on overflow
        if (mant_sum == '0 || res_exp <= 5'sd0) begin
            result = '0;
        end else if (res_exp > FP8_EXP_MAX) begin
            result = {res_sign, FP8_MAX_MAG};
        end else begin
            result = {res_sign, exp_t'(res_exp[2:0]), mant_t'(norm_mant[3:0])};
        end
    end

endmodule

//--- hw/fp8_pkg.sv
package fp8_pkg;

    // fp8 layout is sign, 3-bit exponent, 4-bit mantissa
    typedef logic [7:0] fp8_t;
    typedef logic [2:0] exp_t;
    typedef logic [3:0] mant_t;

    // Scratchpad and arbiter
    typedef logic [3:0] sp_addr_t;
    typedef logic [2:0] client_t;

    // Field positions inside fp8_t
    localparam int FP8_SIGN_BIT = 7;
    localparam int FP8_EXP_HI   = 6;
    localparam int FP8_EXP_LO   = 4;
    localparam int FP8_MANT_HI  = 3;

    localparam int FP8_BIAS    = 3;
    localparam int FP8_EXP_MAX = 7;

    // Exponent 7 and mantissa 15 without the sign
    localparam logic [6:0] FP8_MAX_MAG = 7'h7F;

    localparam int SP_DEPTH    = 16;
    localparam int NUM_CLIENTS = 3;

    // Bit position of each client in req/gnt/rvalid
    localparam int CLIENT_HOST = 0;
    localparam int CLIENT_ADD  = 1;
    localparam int CLIENT_MUL  = 2;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_RD_A,
        ENG_RD_B,
        ENG_EXEC,
        ENG_WR
    } eng_state_t;

endpackage
